// File: hw/icache_pkg.sv
`default_nettype none

package icache_pkg;

    // ==========================================================
    // Cache geometry
    // ==========================================================
    localparam int ADDR_W     = 32;
    localparam int WORD_W     = 64;
    localparam int LINE_W     = 128;
    localparam int LINE_WORDS = LINE_W / WORD_W;
    localparam int N_WAYS     = 4;
    localparam int N_SETS     = 16;
    localparam int WAY_W      = $clog2(N_WAYS);
    localparam int BYTE_W     = $clog2(WORD_W / 8);
    localparam int OFFS_W     = $clog2(LINE_WORDS);
    localparam int SET_W      = $clog2(N_SETS);
    // Whatever is left above offset and index
    localparam int TAG_W      = ADDR_W - SET_W - OFFS_W - BYTE_W;

    // Controller state encoding
    localparam int              ST_W        = 3;
    localparam logic [ST_W-1:0] ST_IDLE     = 3'd0;
    localparam logic [ST_W-1:0] ST_COMPARE  = 3'd1;
    localparam logic [ST_W-1:0] ST_MEM_REQ  = 3'd2;
    localparam logic [ST_W-1:0] ST_MEM_WAIT = 3'd3;
    localparam logic [ST_W-1:0] ST_RESP     = 3'd4;

    // One line, written flat from memory and read back word by word
    // Word 0 sits in the upper half of the flat view
    typedef union packed {
        logic [LINE_W-1:0]                 flat;
        logic [LINE_WORDS-1:0][WORD_W-1:0] words;
    } line_t;

    // ==========================================================
    // Address fields
    // ==========================================================
    function automatic logic [SET_W-1:0] addr_set(input logic [ADDR_W-1:0] addr);
        return addr[BYTE_W+OFFS_W +: SET_W];
    endfunction

    function automatic logic [TAG_W-1:0] addr_tag(input logic [ADDR_W-1:0] addr);
        return addr[ADDR_W-1 -: TAG_W];
    endfunction

    function automatic logic [OFFS_W-1:0] addr_offs(input logic [ADDR_W-1:0] addr);
        return addr[BYTE_W +: OFFS_W];
    endfunction

    // Line-aligned address for the memory request
    function automatic logic [ADDR_W-1:0] addr_line(input logic [ADDR_W-1:0] addr);
        return {addr[ADDR_W-1:BYTE_W+OFFS_W], {(BYTE_W+OFFS_W){1'b0}}};
    endfunction

endpackage

`default_nettype wire

// File: hw/icache_tag_store.sv
`default_nettype none
`timescale 1ns/10ps

module icache_tag_store
    import icache_pkg::*;
(
    input  wire              clk_i,
    input  wire              rst_i,
    // Lookup from the controller
    input  wire              lookup_i,
    input  wire [ADDR_W-1:0] addr_i,
    // Refill and flush
    input  wire              fill_i,
    input  wire              flush_i,
    // Lookup result
    output logic             hit_o,
    output logic [WAY_W-1:0] hit_way_o,
    output logic [WAY_W-1:0] victim_way_o,
    output logic             busy_o
);

    // Registered lookup fields
    logic [SET_W-1:0]  set_q;
    logic [TAG_W-1:0]  tag_q;

    // Distributed-style arrays, read asynchronously
    logic [TAG_W-1:0]  tag_mem   [N_WAYS][N_SETS];
    logic              valid_mem [N_WAYS][N_SETS];

    // One FIFO pointer per set, points at the next way to replace
    logic [WAY_W-1:0]  fifo_q    [N_SETS];

    // Clearing sweep
    logic              busy_q;
    logic [SET_W-1:0]  sweep_q;

    logic [N_WAYS-1:0] way_hit;

    // ==========================================================
    // Lookup address register
    // ==========================================================
    always_ff @(posedge clk_i)
    begin
        if (lookup_i)
        begin
            set_q <= addr_set(addr_i);
            tag_q <= addr_tag(addr_i);
        end
    end

    // ==========================================================
    // Clearing sweep, one set per cycle
    // ==========================================================
    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            busy_q  <= 1'b1;
            sweep_q <= '0;
        end
        else if (busy_q)
        begin
            sweep_q <= sweep_q + 1'b1;
            // Last set cleared this cycle
            if (sweep_q == SET_W'(N_SETS - 1))
                busy_q <= 1'b0;
        end
        else if (flush_i)
        begin
            // Flush only arrives while the controller sits idle
            busy_q  <= 1'b1;
            sweep_q <= '0;
        end
    end

    // Valid bits and FIFO pointers share the sweep and the fill
    always_ff @(posedge clk_i)
    begin
        if (busy_q)
        begin
            for (int w = 0; w < N_WAYS; w++)
                valid_mem[w][sweep_q] <= 1'b0;
            fifo_q[sweep_q] <= '0;
        end
        else if (fill_i)
        begin
            valid_mem[victim_way_o][set_q] <= 1'b1;
            // Next refill of this set goes to the following way
            fifo_q[set_q] <= fifo_q[set_q] + 1'b1;
        end
    end

    // Tag written into the victim way on refill
    always_ff @(posedge clk_i)
    begin
        if (fill_i)
            tag_mem[victim_way_o][set_q] <= tag_q;
    end

    // ==========================================================
    // Hit compare across all ways
    // ==========================================================
    always_comb
    begin
        for (int w = 0; w < N_WAYS; w++)
            way_hit[w] = valid_mem[w][set_q] && (tag_mem[w][set_q] == tag_q);
    end

    // Encode the hit way, at most one way can match
    always_comb
    begin
        hit_way_o = '0;
        for (int w = 0; w < N_WAYS; w++)
            if (way_hit[w])
                hit_way_o = WAY_W'(w);
    end

    assign hit_o        = |way_hit;
    assign victim_way_o = fifo_q[set_q];
    assign busy_o       = busy_q;

endmodule

`default_nettype wire

// File: hw/icache_line_store.sv
`default_nettype none
`timescale 1ns/10ps

module icache_line_store
    import icache_pkg::*;
(
    input  wire                     clk_i,
    // Lookup from the controller
    input  wire                     lookup_i,
    input  wire [ADDR_W-1:0]        addr_i,
    // Refill into one way
    input  wire                     fill_i,
    input  wire [WAY_W-1:0]         fill_way_i,
    input  wire [LINE_W-1:0]        fill_line_i,
    // All ways of the looked-up set
    output line_t [N_WAYS-1:0]      lines_o
);

    // Set index taken on lookup, shared by every way
    logic [SET_W-1:0] set_q;

    always_ff @(posedge clk_i)
    begin
        if (lookup_i)
            set_q <= addr_set(addr_i);
    end

    // ==========================================================
    // One block-RAM-style array per way
    // ==========================================================
    for (genvar w = 0; w < N_WAYS; w++)
    begin : g_way
        line_t mem [N_SETS];
        line_t rd_q;

        // Refill write and synchronous read on the same set
        always_ff @(posedge clk_i)
        begin
            if (fill_i && (fill_way_i == WAY_W'(w)))
                mem[set_q].flat <= fill_line_i;
            // Read-first, data lands one cycle after the index
            rd_q <= mem[set_q];
        end

        assign lines_o[w] = rd_q;
    end

endmodule

`default_nettype wire

// File: hw/icache_ctrl.sv
`default_nettype none
`timescale 1ns/10ps

module icache_ctrl
    import icache_pkg::*;
(
    input  wire                     clk_i,
    input  wire                     rst_i,
    // Processor request
    input  wire                     req_valid_i,
    input  wire [ADDR_W-1:0]        req_addr_i,
    output logic                    req_ready_o,
    // Processor response
    output logic                    resp_valid_o,
    output logic [WORD_W-1:0]       resp_data_o,
    input  wire                     resp_ready_i,
    input  wire                     flush_i,
    // Tag store and line store
    input  wire                     busy_i,
    input  wire                     hit_i,
    input  wire [WAY_W-1:0]         hit_way_i,
    input  wire line_t [N_WAYS-1:0] lines_i,
    output logic                    lookup_o,
    output logic                    fill_o,
    // Memory side
    output logic                    mem_req_valid_o,
    output logic [ADDR_W-1:0]       mem_req_addr_o,
    input  wire                     mem_req_ready_i,
    input  wire                     mem_resp_valid_i,
    input  wire [LINE_W-1:0]        mem_resp_line_i
);

    logic [ST_W-1:0]   state_q;
    logic [ST_W-1:0]   state_d;
    // Low in the first compare cycle while the line store reads
    logic              stage_q;
    logic              accept;

    // Request held for the miss path and the word select
    logic [ADDR_W-1:0] line_addr_q;
    logic [OFFS_W-1:0] offs_q;
    logic [OFFS_W-1:0] word_idx;

    line_t             hit_line;
    line_t             mem_line;
    logic [WORD_W-1:0] hit_word;
    logic [WORD_W-1:0] mem_word;
    logic [WORD_W-1:0] resp_data_q;

    // ==========================================================
    // Handshakes
    // ==========================================================
    assign req_ready_o = (state_q == ST_IDLE) && !busy_i;
    // A flush in the same cycle takes priority over a request
    assign accept      = req_valid_i && req_ready_o && !flush_i;
    assign lookup_o    = accept;

    assign mem_req_valid_o = (state_q == ST_MEM_REQ);
    assign mem_req_addr_o  = line_addr_q;
    // Refill strobe, one cycle with the memory line
    assign fill_o          = (state_q == ST_MEM_WAIT) && mem_resp_valid_i;

    assign resp_valid_o = (state_q == ST_RESP);
    assign resp_data_o  = resp_data_q;

    // ==========================================================
    // Word select through the line union
    // ==========================================================
    // Offset 0 maps to the upper word
    assign word_idx = OFFS_W'(LINE_WORDS - 1) - offs_q;

    always_comb
    begin
        hit_line      = lines_i[hit_way_i];
        mem_line.flat = mem_resp_line_i;
        hit_word      = hit_line.words[word_idx];
        mem_word      = mem_line.words[word_idx];
    end

    // ==========================================================
    // FSM
    // ==========================================================
    always_comb
    begin
        state_d = state_q;
        case (state_q)
            ST_IDLE:
                if (accept)
                    state_d = ST_COMPARE;
            ST_COMPARE:
                // Tag result and line data both valid in the second cycle
                if (stage_q)
                    state_d = hit_i ? ST_RESP : ST_MEM_REQ;
            ST_MEM_REQ:
                if (mem_req_ready_i)
                    state_d = ST_MEM_WAIT;
            ST_MEM_WAIT:
                if (mem_resp_valid_i)
                    state_d = ST_RESP;
            ST_RESP:
                if (resp_ready_i)
                    state_d = ST_IDLE;
            default:
                state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            state_q <= ST_IDLE;
            stage_q <= 1'b0;
        end
        else
        begin
            state_q <= state_d;
            stage_q <= (state_q == ST_COMPARE) && !stage_q;
        end
    end

    // Request fields and response word
    always_ff @(posedge clk_i)
    begin
        if (accept)
        begin
            line_addr_q <= addr_line(req_addr_i);
            offs_q      <= addr_offs(req_addr_i);
        end
        // Loaded once per request, then held until it transfers
        if ((state_q == ST_COMPARE) && stage_q && hit_i)
            resp_data_q <= hit_word;
        else if (fill_o)
            resp_data_q <= mem_word;
    end

endmodule

`default_nettype wire

// File: hw/icache_top.sv
`default_nettype none
`timescale 1ns/10ps

module icache_top
    import icache_pkg::*;
(
    input  wire               clk_i,
    input  wire               rst_i,
    // Processor request
    input  wire               req_valid_i,
    input  wire [ADDR_W-1:0]  req_addr_i,
    output logic              req_ready_o,
    // Processor response
    output logic              resp_valid_o,
    output logic [WORD_W-1:0] resp_data_o,
    input  wire               resp_ready_i,
    input  wire               flush_i,
    // Memory side
    output logic              mem_req_valid_o,
    output logic [ADDR_W-1:0] mem_req_addr_o,
    input  wire               mem_req_ready_i,
    input  wire               mem_resp_valid_i,
    input  wire [LINE_W-1:0]  mem_resp_line_i
);

    // Controller to stores
    logic               lookup;
    logic               fill;

    // Stores to controller
    logic               hit;
    logic [WAY_W-1:0]   hit_way;
    logic [WAY_W-1:0]   victim_way;
    logic               busy;
    line_t [N_WAYS-1:0] lines;

    // ==========================================================
    // Tag store and line store side by side
    // ==========================================================
    icache_tag_store tag_store_i (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .lookup_i     (lookup),
        .addr_i       (req_addr_i),
        .fill_i       (fill),
        .flush_i      (flush_i),
        .hit_o        (hit),
        .hit_way_o    (hit_way),
        .victim_way_o (victim_way),
        .busy_o       (busy)
    );

    // Refill lands in the way the tag store picked
    icache_line_store line_store_i (
        .clk_i       (clk_i),
        .lookup_i    (lookup),
        .addr_i      (req_addr_i),
        .fill_i      (fill),
        .fill_way_i  (victim_way),
        .fill_line_i (mem_resp_line_i),
        .lines_o     (lines)
    );

    icache_ctrl ctrl_i (
        .clk_i            (clk_i),
        .rst_i            (rst_i),
        .req_valid_i      (req_valid_i),
        .req_addr_i       (req_addr_i),
        .req_ready_o      (req_ready_o),
        .resp_valid_o     (resp_valid_o),
        .resp_data_o      (resp_data_o),
        .resp_ready_i     (resp_ready_i),
        .flush_i          (flush_i),
        .busy_i           (busy),
        .hit_i            (hit),
        .hit_way_i        (hit_way),
        .lines_i          (lines),
        .lookup_o         (lookup),
        .fill_o           (fill),
        .mem_req_valid_o  (mem_req_valid_o),
        .mem_req_addr_o   (mem_req_addr_o),
        .mem_req_ready_i  (mem_req_ready_i),
        .mem_resp_valid_i (mem_resp_valid_i),
        .mem_resp_line_i  (mem_resp_line_i)
    );

endmodule

`default_nettype wire

// File: sim/icache_sva.sv
`default_nettype none
`timescale 1ns/10ps

module icache_sva
    import icache_pkg::*;
(
    input wire              clk_i,
    input wire              rst_i,
    input wire              req_ready_i,
    input wire              resp_valid_i,
    input wire [WORD_W-1:0] resp_data_i,
    input wire              resp_ready_i,
    input wire              mem_req_valid_i,
    input wire [ADDR_W-1:0] mem_req_addr_i,
    input wire              mem_req_ready_i
);

    // ==========================================================
    // Processor response handshake
    // ==========================================================
    // Response held with its data until it transfers
    resp_hold: assert property (@(posedge clk_i) disable iff (rst_i)
        resp_valid_i && !resp_ready_i |=> resp_valid_i && $stable(resp_data_i))
        else $error("resp_valid_o dropped or resp_data_o changed before transfer");

    // No new request while a response is pending
    ready_low: assert property (@(posedge clk_i) disable iff (rst_i)
        resp_valid_i |-> !req_ready_i)
        else $error("req_ready_o high while resp_valid_o is high");

    // ==========================================================
    // Memory request handshake
    // ==========================================================
    mem_req_hold: assert property (@(posedge clk_i) disable iff (rst_i)
        mem_req_valid_i && !mem_req_ready_i |=> mem_req_valid_i && $stable(mem_req_addr_i))
        else $error("mem_req_valid_o dropped or mem_req_addr_o changed before transfer");

endmodule

`default_nettype wire

// File: sim/icache_tb.sv
`default_nettype none
`timescale 1ns/10ps

module icache_tb
    import icache_pkg::*;
();

    localparam int TIMEOUT = 200;
    localparam int CHK_W   = 128;

    logic              clk_i;
    logic              rst_i;
    logic              req_valid_i;
    logic [ADDR_W-1:0] req_addr_i;
    logic              req_ready_o;
    logic              resp_valid_o;
    logic [WORD_W-1:0] resp_data_o;
    logic              resp_ready_i;
    logic              flush_i;
    logic              mem_req_valid_o;
    logic [ADDR_W-1:0] mem_req_addr_o;
    logic              mem_req_ready_i;
    logic              mem_resp_valid_i;
    logic [LINE_W-1:0] mem_resp_line_i;

    // Separate LCG streams for memory timing and addresses
    int unsigned       mem_seed;
    int unsigned       addr_seed;
    int                mem_req_count;
    logic [ADDR_W-1:0] exp_line_addr;

    // Memory model state
    logic              mem_busy;
    int                mem_delay;
    logic [ADDR_W-1:0] mem_addr;

    icache_top dut_i (
        .clk_i            (clk_i),
        .rst_i            (rst_i),
        .req_valid_i      (req_valid_i),
        .req_addr_i       (req_addr_i),
        .req_ready_o      (req_ready_o),
        .resp_valid_o     (resp_valid_o),
        .resp_data_o      (resp_data_o),
        .resp_ready_i     (resp_ready_i),
        .flush_i          (flush_i),
        .mem_req_valid_o  (mem_req_valid_o),
        .mem_req_addr_o   (mem_req_addr_o),
        .mem_req_ready_i  (mem_req_ready_i),
        .mem_resp_valid_i (mem_resp_valid_i),
        .mem_resp_line_i  (mem_resp_line_i)
    );

    bind icache_top icache_sva sva_i (
        .clk_i           (clk_i),
        .rst_i           (rst_i),
        .req_ready_i     (req_ready_o),
        .resp_valid_i    (resp_valid_o),
        .resp_data_i     (resp_data_o),
        .resp_ready_i    (resp_ready_i),
        .mem_req_valid_i (mem_req_valid_o),
        .mem_req_addr_i  (mem_req_addr_o),
        .mem_req_ready_i (mem_req_ready_i)
    );

    // 40 ns clock
    always #20 clk_i = ~clk_i;

    // ==========================================================
    // Helpers
    // ==========================================================
    function automatic int unsigned lcg_next(input int unsigned s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // Word address in the upper half and its inverse in the lower half
    function automatic logic [WORD_W-1:0] model_word(input logic [ADDR_W-1:0] a);
        logic [ADDR_W-1:0] wa;
        wa = {a[ADDR_W-1:BYTE_W], {BYTE_W{1'b0}}};
        return {wa, ~wa};
    endfunction

    // Offset 0 word in the upper half
    function automatic logic [LINE_W-1:0] model_line(input logic [ADDR_W-1:0] la);
        return {model_word(la), model_word(la + ADDR_W'(WORD_W / 8))};
    endfunction

    task automatic fail_stop(input string why);
        $display("%s", why);
        $display("test failed");
        $fatal(1);
    endtask

    task automatic check(input string name, input logic [CHK_W-1:0] got,
                         input logic [CHK_W-1:0] exp);
        if (got !== exp)
            fail_stop($sformatf("[ERROR] %0t: %s is %0h, expected %0h", $time, name, got, exp));
    endtask

    // Inputs change and outputs are read 2 ns after the edge
    task automatic tick();
        @(posedge clk_i);
        #2;
    endtask

    // ==========================================================
    // Memory model with random ready and response delay
    // ==========================================================
    always @(posedge clk_i)
    begin
        #2;
        mem_resp_valid_i = 1'b0;
        // Ready drops now and then so the request must hold
        mem_seed        = lcg_next(mem_seed);
        mem_req_ready_i = (((mem_seed >> 16) % 4) != 0);
        if (!mem_busy && mem_req_valid_o && mem_req_ready_i)
        begin
            // Request transfers at the coming edge
            check("mem_req_addr_o", CHK_W'(mem_req_addr_o), CHK_W'(exp_line_addr));
            mem_addr      = mem_req_addr_o;
            mem_seed      = lcg_next(mem_seed);
            mem_delay     = int'((mem_seed >> 16) % 8);
            mem_busy      = 1'b1;
            mem_req_count = mem_req_count + 1;
        end
        else if (mem_busy)
        begin
            if (mem_delay == 0)
            begin
                // One-cycle line beat
                mem_resp_valid_i = 1'b1;
                mem_resp_line_i  = model_line(mem_addr);
                mem_busy         = 1'b0;
            end
            else
                mem_delay = mem_delay - 1;
        end
    end

    // ==========================================================
    // Fetch with optional response stall
    // ==========================================================
    task automatic fetch(input logic [ADDR_W-1:0] addr, input int stall, output int lat);
        int                t;
        logic [WORD_W-1:0] held;
        t = 0;
        while (!req_ready_o)
        begin
            tick();
            t++;
            if (t > TIMEOUT)
                fail_stop("Timeout: req_ready_o never rose before a fetch");
        end
        exp_line_addr = addr & ~ADDR_W'(LINE_W / 8 - 1);
        req_valid_i   = 1'b1;
        req_addr_i    = addr;
        tick();
        // Request taken at that edge so the address bus gets scrambled
        req_valid_i = 1'b0;
        req_addr_i  = ~addr;
        lat         = 0;
        while (!resp_valid_o)
        begin
            check("req_ready_o", CHK_W'(req_ready_o), CHK_W'(0));
            tick();
            lat++;
            if (lat > TIMEOUT)
                fail_stop("Timeout: resp_valid_o never rose after a request");
        end
        check("resp_data_o", CHK_W'(resp_data_o), CHK_W'(model_word(addr)));
        held = resp_data_o;
        // Response must hold under back-pressure
        for (int i = 0; i < stall; i++)
        begin
            tick();
            check("resp_valid_o", CHK_W'(resp_valid_o), CHK_W'(1));
            check("resp_data_o", CHK_W'(resp_data_o), CHK_W'(held));
            check("req_ready_o", CHK_W'(req_ready_o), CHK_W'(0));
        end
        resp_ready_i = 1'b1;
        tick();
        resp_ready_i = 1'b0;
        check("resp_valid_o", CHK_W'(resp_valid_o), CHK_W'(0));
        check("req_ready_o", CHK_W'(req_ready_o), CHK_W'(1));
    endtask

    // Counts cycles with req_ready_o low including the current one
    task automatic count_ready_low(output int n);
        n = 0;
        while (!req_ready_o)
        begin
            n++;
            if (n > TIMEOUT)
                fail_stop("Timeout: req_ready_o stayed low after the clearing sweep");
            tick();
        end
    endtask

    // ==========================================================
    // Directed tests
    // ==========================================================
    task automatic hit_after_miss();
        int lat;
        int base;
        base = mem_req_count;
        fetch(32'h0000_1008, 0, lat);
        check("memory requests", CHK_W'(mem_req_count - base), CHK_W'(1));
        // Other word of the same line
        fetch(32'h0000_1000, 0, lat);
        check("memory requests", CHK_W'(mem_req_count - base), CHK_W'(1));
        check("hit latency", CHK_W'(lat), CHK_W'(2));
    endtask

    task automatic fifo_eviction();
        int lat;
        int base;
        base = mem_req_count;
        // Five tags in set 5
        for (int i = 0; i <= N_WAYS; i++)
            fetch(32'h0004_0058 + ADDR_W'(i * 256), 0, lat);
        check("memory requests", CHK_W'(mem_req_count - base), CHK_W'(N_WAYS + 1));
        for (int i = 1; i <= N_WAYS; i++)
        begin
            fetch(32'h0004_0050 + ADDR_W'(i * 256), 0, lat);
            check("hit latency", CHK_W'(lat), CHK_W'(2));
        end
        check("memory requests", CHK_W'(mem_req_count - base), CHK_W'(N_WAYS + 1));
        // Oldest line was the victim
        fetch(32'h0004_0058, 0, lat);
        check("memory requests", CHK_W'(mem_req_count - base), CHK_W'(N_WAYS + 2));
    endtask

    task automatic flush_refetch();
        int lat;
        int base;
        int n;
        fetch(32'h0000_1000, 0, lat);
        check("hit latency", CHK_W'(lat), CHK_W'(2));
        base    = mem_req_count;
        flush_i = 1'b1;
        tick();
        flush_i = 1'b0;
        count_ready_low(n);
        check("flush sweep cycles", CHK_W'(n), CHK_W'(N_SETS));
        fetch(32'h0000_1000, 0, lat);
        check("memory requests", CHK_W'(mem_req_count - base), CHK_W'(1));
    endtask

    task automatic back_pressure();
        int lat;
        // Stall on a hit and then on a miss
        fetch(32'h0000_1008, 6, lat);
        check("hit latency", CHK_W'(lat), CHK_W'(2));
        fetch(32'h0000_2010, 4, lat);
    endtask

    task automatic random_fetches();
        int                lat;
        int                stall;
        logic [ADDR_W-1:0] addr;
        for (int i = 0; i < 60; i++)
        begin
            addr_seed = lcg_next(addr_seed);
            addr      = (addr_seed >> 8) & 32'h0000_07F8;
            addr_seed = lcg_next(addr_seed);
            stall     = int'((addr_seed >> 16) % 4);
            fetch(addr, stall, lat);
        end
    endtask

    // ==========================================================
    // Main sequence
    // ==========================================================
    initial
    begin
        int n;
        clk_i            = 1'b0;
        rst_i            = 1'b1;
        req_valid_i      = 1'b0;
        req_addr_i       = '0;
        resp_ready_i     = 1'b0;
        flush_i          = 1'b0;
        mem_req_ready_i  = 1'b1;
        mem_resp_valid_i = 1'b0;
        mem_resp_line_i  = '0;
        mem_seed         = 40234;
        addr_seed        = 40234;
        mem_req_count    = 0;
        exp_line_addr    = '0;
        mem_busy         = 1'b0;
        mem_delay        = 0;
        mem_addr         = '0;

        repeat (4) tick();
        check("req_ready_o", CHK_W'(req_ready_o), CHK_W'(0));
        check("resp_valid_o", CHK_W'(resp_valid_o), CHK_W'(0));
        check("mem_req_valid_o", CHK_W'(mem_req_valid_o), CHK_W'(0));
        rst_i = 1'b0;
        count_ready_low(n);
        check("reset sweep cycles", CHK_W'(n), CHK_W'(N_SETS));

        hit_after_miss();
        fifo_eviction();
        flush_refetch();
        back_pressure();
        random_fetches();

        $display("test passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: src.f
hw/icache_pkg.sv
hw/icache_tag_store.sv
hw/icache_line_store.sv
hw/icache_ctrl.sv
hw/icache_top.sv
sim/icache_sva.sv
sim/icache_tb.sv

// File: Makefile
# Verilator build and run of the instruction cache testbench

TOP := icache_tb
BIN := obj_dir/V$(TOP)

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert --timescale 1ns/10ps \
		--top-module $(TOP) -f src.f

# The run passes only when the pass line shows up in the output
run: compile
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "test passed"

clean:
	rm -rf obj_dir
